//--- design/crDct.sv
// Cr 8x8 forward DCT top level, row stage feeding column stage
`timescale 1ns/1ps
`default_nettype none

module crDct import dctPkg::*; (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic enable,
	input  wire pixelT dataIn,
	output coefBlockT coefOut,
	output logic      outputEnable
);

	logic [2:0] colIdx;
	logic       rowValid;
	logic [2:0] rowIdx;
	coefRowT    rowCoef;

	weightColT rowWeightCol;
	weightColT colWeightCol;

	// the row stage reads the column of T for the current sample position
	dctBasisRom rowWeights (
		.idx     (colIdx),
		.weights (rowWeightCol)
	);

	// the column stage reads the column of T for the row being absorbed
	dctBasisRom colWeights (
		.idx     (rowIdx),
		.weights (colWeightCol)
	);

	dctRowStage rowStage (
		.clk      (clk),
		.rst      (rst),
		.enable   (enable),
		.dataIn   (dataIn),
		.weights  (rowWeightCol),
		.colIdx   (colIdx),
		.rowValid (rowValid),
		.rowIdx   (rowIdx),
		.rowCoef  (rowCoef)
	);

	dctColumnStage columnStage (
		.clk          (clk),
		.rst          (rst),
		.rowValid     (rowValid),
		.rowIdx       (rowIdx),
		.rowCoef      (rowCoef),
		.weights      (colWeightCol),
		.coefOut      (coefOut),
		.outputEnable (outputEnable)
	);

endmodule

`default_nettype wire

//--- design/dctBasisRom.sv
// DCT cosine table returning one column of the 8x8 weight matrix per index
`timescale 1ns/1ps
`default_nettype none

module dctBasisRom import dctPkg::*; (
	input  wire logic [2:0] idx,
	output weightColT       weights
);

	// cos(k*pi/16) / 2, scaled by 2^14
	localparam weightT cos1 = 14'sd8035;
	localparam weightT cos2 = 14'sd7568;
	localparam weightT cos3 = 14'sd6811;
	localparam weightT cos4 = 14'sd5793;
	localparam weightT cos5 = 14'sd4551;
	localparam weightT cos6 = 14'sd3135;
	localparam weightT cos7 = 14'sd1598;

	// each entry lists T[0..7][idx], top row first
	always_comb begin
		case (idx)
			3'd0: begin
				weights = '{cos4, cos1, cos2, cos3, cos4, cos5, cos6, cos7};
			end
			3'd1: begin
				weights = '{cos4, cos3, cos6, -cos7, -cos4, -cos1, -cos2, -cos5};
			end
			3'd2: begin
				weights = '{cos4, cos5, -cos6, -cos1, -cos4, cos7, cos2, cos3};
			end
			3'd3: begin
				weights = '{cos4, cos7, -cos2, -cos5, cos4, cos3, -cos6, -cos1};
			end
			3'd4: begin
				weights = '{cos4, -cos7, -cos2, cos5, cos4, -cos3, -cos6, cos1};
			end
			3'd5: begin
				weights = '{cos4, -cos5, -cos6, cos1, -cos4, -cos7, cos2, -cos3};
			end
			3'd6: begin
				weights = '{cos4, -cos3, cos6, cos7, -cos4, cos1, -cos2, cos5};
			end
			default: begin
				weights = '{cos4, -cos1, cos2, -cos3, cos4, -cos5, cos6, -cos7};
			end
		endcase
	end

endmodule

`default_nettype wire

//--- design/dctColumnStage.sv
// Cr DCT column stage, accumulating the 8 transformed rows into 64 coefficients
`timescale 1ns/1ps
`default_nettype none

`include "dct_defines.svh"

module dctColumnStage import dctPkg::*; (
	input  wire logic      clk,
	input  wire logic      rst,
	input  wire logic      rowValid,
	input  wire logic [2:0] rowIdx,
	input  wire coefRowT   rowCoef,
	input  wire weightColT weights,
	output coefBlockT      coefOut,
	output logic           outputEnable
);

	// accumulator [v][u] collects T[v][r] * Y[r][u] over the rows r
	logic signed [`COL_ACC_W-1:0] colAcc [`DCT_N][`DCT_N];
	logic signed [`COL_ACC_W-1:0] colProd [`DCT_N][`DCT_N];
	logic signed [`COL_ACC_W-1:0] colSum [`DCT_N][`DCT_N];

	logic lastRow;

	assign lastRow = rowValid && rowIdx == 3'd7;

	// row 0 loads, later rows add
	always_comb begin
		for (int v = 0; v < `DCT_N; v++) begin
			for (int u = 0; u < `DCT_N; u++) begin
				colProd[v][u] = weights[v] * rowCoef[u];
				if (rowIdx == 3'd0) begin
					colSum[v][u] = colProd[v][u];
				end else begin
					colSum[v][u] = colAcc[v][u] + colProd[v][u];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rowValid) begin
			for (int v = 0; v < `DCT_N; v++) begin
				for (int u = 0; u < `DCT_N; u++) begin
					colAcc[v][u] <= colSum[v][u];
				end
			end
		end
	end

	// the last row completes the block, so round straight from the sum
	always_ff @(posedge clk) begin
		if (rst) begin
			coefOut <= '0;
			outputEnable <= 1'b0;
		end else begin
			outputEnable <= lastRow;
			if (lastRow) begin
				for (int v = 0; v < `DCT_N; v++) begin
					for (int u = 0; u < `DCT_N; u++) begin
						coefOut[v*`DCT_N+u] <= roundCoef(colSum[v][u]);
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- design/dctPkg.sv
// Cr DCT shared types and the coefficient rounding rule
`default_nettype none

`include "dct_defines.svh"

package dctPkg;

	typedef logic [`PIXEL_W-1:0] pixelT;

	typedef logic signed [`WEIGHT_W-1:0] weightT;

	// index k holds T[k][n] for the column n being read
	typedef weightT [0:`DCT_N-1] weightColT;

	typedef logic signed [`COEF_W-1:0] coefT;

	typedef coefT [0:`DCT_N-1] coefRowT;

	// index v*8+u
	typedef coefT [0:`DCT_N*`DCT_N-1] coefBlockT;

	// keep bits 24..14, bump by one when bit 13 is set (round half up)
	function automatic coefT roundCoef(input logic signed [`COL_ACC_W-1:0] sum);
		return coefT'(sum[`FRAC_W+`COEF_W-1:`FRAC_W] + sum[`FRAC_W-1]);
	endfunction

endpackage

`default_nettype wire

//--- design/dctRowStage.sv
// Cr DCT row stage, a 1-D transform of each incoming row of 8 pixels
`timescale 1ns/1ps
`default_nettype none

`include "dct_defines.svh"

module dctRowStage import dctPkg::*; (
	input  wire logic      clk,
	input  wire logic      rst,
	input  wire logic      enable,
	input  wire pixelT     dataIn,
	input  wire weightColT weights,
	output logic [2:0]     colIdx,
	output logic           rowValid,
	output logic [2:0]     rowIdx,
	output coefRowT        rowCoef
);

	// row position inside the current block
	logic [2:0] rowCount;

	logic rowDone;

	// pixel widened with a zero sign bit so the products stay signed
	logic signed [`PIXEL_W:0] pixelS;

	logic signed [`ROW_ACC_W-1:0] rowAcc [`DCT_N];
	logic signed [`ROW_ACC_W-1:0] prod [`DCT_N];
	logic signed [`ROW_ACC_W-1:0] rowSum [`DCT_N];
	logic signed [`ROW_ACC_W-1:0] dcShifted;

	assign pixelS = {1'b0, dataIn};
	assign rowDone = enable && colIdx == 3'd7;

	// sample and row counters; dropping enable restarts at row 0
	always_ff @(posedge clk) begin
		if (rst) begin
			colIdx <= '0;
			rowCount <= '0;
		end else if (!enable) begin
			colIdx <= '0;
			rowCount <= '0;
		end else begin
			colIdx <= colIdx + 3'd1;
			if (colIdx == 3'd7) begin
				rowCount <= rowCount + 3'd1;
			end
		end
	end

	// running sums, column 0 starts a new row instead of adding
	always_comb begin
		for (int u = 0; u < `DCT_N; u++) begin
			prod[u] = pixelS * weights[u];
			if (colIdx == 3'd0) begin
				rowSum[u] = prod[u];
			end else begin
				rowSum[u] = rowAcc[u] + prod[u];
			end
		end
		// the other weight rows sum to zero, so only u = 0 needs the level shift
		dcShifted = rowSum[0] - `ROW_ACC_W'(`DC_OFFSET);
	end

	always_ff @(posedge clk) begin
		if (enable) begin
			for (int u = 0; u < `DCT_N; u++) begin
				rowAcc[u] <= rowSum[u];
			end
		end
	end

	// finished row goes out together with its index
	always_ff @(posedge clk) begin
		if (rowDone) begin
			rowCoef[0] <= roundCoef(dcShifted);
			for (int u = 1; u < `DCT_N; u++) begin
				rowCoef[u] <= roundCoef(rowSum[u]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rowValid <= 1'b0;
			rowIdx <= '0;
		end else begin
			rowValid <= rowDone;
			if (rowDone) begin
				rowIdx <= rowCount;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/dct_defines.svh
// Cr DCT widths, block size, fixed-point fraction and level-shift constant
`ifndef DCT_DEFINES_SVH
`define DCT_DEFINES_SVH

// samples per row and rows per block
`define DCT_N 8

// unsigned input sample
`define PIXEL_W 8

// cosine weights are signed with 14 fraction bits
`define WEIGHT_W 14
`define FRAC_W 14

// rounded coefficient handed to the quantizer
`define COEF_W 11

// accumulator widths of the row and column stages
`define ROW_ACC_W 25
`define COL_ACC_W 28

// 128 * 8 * 5793, removed once from the u = 0 row sum instead of
// subtracting 128 from every pixel
`define DC_OFFSET 5932032

`endif

//--- flist.f
+incdir+design
design/dctPkg.sv
design/dctBasisRom.sv
design/dctRowStage.sv
design/dctColumnStage.sv
design/crDct.sv
tests/crDctTb.sv

//--- run.sh
#!/bin/sh
# build the Cr DCT testbench with Verilator, run it, then search the log
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module crDctTb \
	-o crDctSim \
	&& ./obj_dir/crDctSim > sim.log \
	|| { echo "build or simulation run failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log \
	&& echo "simulation log shows a pass" \
	|| { echo "simulation log shows no pass"; exit 1; }

//--- tests/crDctTb.sv
// Cr DCT testbench, replays the blocks of the cases file and checks every coefficient
`timescale 1ns/1ps
`default_nettype none

`include "dct_defines.svh"

module crDctTb import dctPkg::*; ();

	localparam int NUM_CASES = 5;
	localparam int LINES_PER_CASE = 17;
	localparam int BLOCK_SIZE = `DCT_N * `DCT_N;
	localparam string CASES_FILE = "tests/crDct_cases.txt";

	logic      clk;
	logic      rst;
	logic      enable;
	pixelT     dataIn;
	coefBlockT coefOut;
	logic      outputEnable;

	int errors = 0;
	int checks = 0;
	int cycle = 0;
	bit loadOk;

	string caseName [NUM_CASES];
	int pixels [NUM_CASES][BLOCK_SIZE];
	int expected [NUM_CASES][BLOCK_SIZE];

	// blocks whose 64th pixel went in, with the cycle their pulse is due
	int pendingCase [$];
	int pendingCycle [$];

	crDct i_crDct (
		.clk          (clk),
		.rst          (rst),
		.enable       (enable),
		.dataIn       (dataIn),
		.coefOut      (coefOut),
		.outputEnable (outputEnable)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic loadCases(output bit ok);
		int fd;
		int n;
		string line;
		string name;
		string lines [$];
		int vals [8];
		ok = 0;
		fd = $fopen(CASES_FILE, "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the cases file %s", CASES_FILE);
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() > 1 && line.substr(0, 0) != "#") begin
				lines.push_back(line);
			end
		end
		$fclose(fd);
		if (lines.size() != NUM_CASES * LINES_PER_CASE) begin
			errors++;
			$display("cases file has %0d data lines, not the %0d needed", lines.size(),
				NUM_CASES * LINES_PER_CASE);
			return;
		end
		for (int b = 0; b < NUM_CASES; b++) begin
			n = $sscanf(lines[b*LINES_PER_CASE], "block %s", name);
			caseName[b] = name;
			// 8 pixel lines, then 8 expected coefficient lines
			for (int r = 0; r < 2 * `DCT_N; r++) begin
				n = $sscanf(lines[b*LINES_PER_CASE+1+r], "%d %d %d %d %d %d %d %d",
					vals[0], vals[1], vals[2], vals[3], vals[4], vals[5], vals[6], vals[7]);
				if (n != 8) begin
					errors++;
					$display("cases file line for block %s is malformed", name);
					return;
				end
				for (int k = 0; k < `DCT_N; k++) begin
					if (r < `DCT_N) begin
						pixels[b][r*`DCT_N+k] = vals[k];
					end else begin
						expected[b][(r-`DCT_N)*`DCT_N+k] = vals[k];
					end
				end
			end
		end
		ok = 1;
	endtask

	// count below 64 leaves a partial block behind
	task automatic sendBlock(input int b, input int count);
		for (int i = 0; i < count; i++) begin
			@(negedge clk);
			enable = 1'b1;
			dataIn = pixelT'(pixels[b][i]);
			if (i == BLOCK_SIZE - 1) begin
				pendingCase.push_back(b);
				pendingCycle.push_back(cycle + 2);
			end
		end
	endtask

	task automatic idleCycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			enable = 1'b0;
			dataIn = '0;
		end
	endtask

	task automatic compareBlock(input int b);
		int got;
		for (int i = 0; i < BLOCK_SIZE; i++) begin
			got = coefT'(coefOut[i]);
			checks++;
			assert (got == expected[b][i]) else begin
				errors++;
				$display("error %s coef %0d: expected %0d, actual %0d", caseName[b], i,
					expected[b][i], got);
			end
		end
	endtask

	task automatic drainPulses();
		int waited;
		waited = 0;
		while (pendingCase.size() > 0 && waited < 20) begin
			idleCycles(1);
			waited++;
		end
		checks++;
		assert (pendingCase.size() == 0) else begin
			errors++;
			$display("timed out waiting for outputEnable, %0d blocks never finished",
				pendingCase.size());
		end
	endtask

	always @(negedge clk) begin : pulseMonitor
		int b;
		int due;
		if (!rst) begin
			if (outputEnable) begin
				checks++;
				assert (pendingCase.size() > 0) else begin
					errors++;
					$display("outputEnable pulsed at cycle %0d with no full block sent", cycle);
				end
				if (pendingCase.size() > 0) begin
					b = pendingCase.pop_front();
					due = pendingCycle.pop_front();
					assert (cycle == due) else begin
						errors++;
						$display("error %s pulse cycle: expected %0d, actual %0d", caseName[b],
							due, cycle);
					end
					compareBlock(b);
				end
			end else begin
				assert (!(pendingCycle.size() > 0 && cycle > pendingCycle[0])) else begin
					errors++;
					$display("no outputEnable pulse for block %s",
						caseName[pendingCase[0]]);
					void'(pendingCase.pop_front());
					void'(pendingCycle.pop_front());
				end
			end
		end
	end

	initial begin
		void'($urandom(14));
		rst = 1'b1;
		enable = 1'b0;
		dataIn = '0;
		loadCases(loadOk);
		repeat (10) @(negedge clk);
		rst = 1'b0;

		// quiet outputs straight after reset
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			checks += 2;
			assert (outputEnable == 1'b0) else begin
				errors++;
				$display("error afterReset outputEnable: expected 0, actual %0d",
					outputEnable);
			end
			assert (coefOut == '0) else begin
				errors++;
				$display("error afterReset coefOut: expected 0, actual %0h", coefOut);
			end
		end

		if (loadOk) begin
			// back-to-back with enable held high
			for (int b = 0; b < NUM_CASES; b++) begin
				sendBlock(b, BLOCK_SIZE);
			end
			drainPulses();
			for (int b = 0; b < NUM_CASES; b++) begin
				idleCycles($urandom % 6);
				sendBlock(b, BLOCK_SIZE);
			end
			drainPulses();
			// partial block aborted by enable, then a full checkerboard
			sendBlock(4, 20);
			idleCycles(3);
			sendBlock(3, BLOCK_SIZE);
			drainPulses();
			idleCycles(6);
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/crDct_cases.txt
# each block: a name line, 8 lines of 8 pixels (rows r = 0..7, columns n = 0..7),
# then 8 lines of 8 expected coefficients (rows v = 0..7, columns u = 0..7)
block allGray
128 128 128 128 128 128 128 128
128 128 128 128 128 128 128 128
128 128 128 128 128 128 128 128
128 128 128 128 128 128 128 128
128 128 128 128 128 128 128 128
128 128 128 128 128 128 128 128
128 128 128 128 128 128 128 128
128 128 128 128 128 128 128 128
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
block allWhite
255 255 255 255 255 255 255 255
255 255 255 255 255 255 255 255
255 255 255 255 255 255 255 255
255 255 255 255 255 255 255 255
255 255 255 255 255 255 255 255
255 255 255 255 255 255 255 255
255 255 255 255 255 255 255 255
255 255 255 255 255 255 255 255
1015 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
block horizontalRamp
0 32 64 96 128 160 192 224
0 32 64 96 128 160 192 224
0 32 64 96 128 160 192 224
0 32 64 96 128 160 192 224
0 32 64 96 128 160 192 224
0 32 64 96 128 160 192 224
0 32 64 96 128 160 192 224
0 32 64 96 128 160 192 224
-127 -583 0 -62 0 -17 0 -6
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
block checkerboard
0 255 0 255 0 255 0 255
255 0 255 0 255 0 255 0
0 255 0 255 0 255 0 255
255 0 255 0 255 0 255 0
0 255 0 255 0 255 0 255
255 0 255 0 255 0 255 0
0 255 0 255 0 255 0 255
255 0 255 0 255 0 255 0
-3 0 0 0 0 0 0 0
0 -33 0 -39 0 -59 0 -167
0 0 0 0 0 0 0 0
0 -39 0 -46 0 -69 0 -197
0 0 0 0 0 0 0 0
0 -59 0 -69 0 -104 0 -294
0 0 0 0 0 0 0 0
0 -167 0 -197 0 -295 0 -838
block randomRows
37 37 37 37 37 37 37 37
201 201 201 201 201 201 201 201
150 150 150 150 150 150 150 150
88 88 88 88 88 88 88 88
240 240 240 240 240 240 240 240
12 12 12 12 12 12 12 12
173 173 173 173 173 173 173 173
99 99 99 99 99 99 99 99
-24 0 0 0 0 0 0 0
13 0 0 0 0 0 0 0
-136 0 0 0 0 0 0 0
-152 0 0 0 0 0 0 0
-71 0 0 0 0 0 0 0
-228 0 0 0 0 0 0 0
-381 0 0 0 0 0 0 0
334 0 0 0 0 0 0 0
